//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - common
    files:
      - common/mipsIsaPkg.sv
      - common/mipsCorePkg.sv
      - common/queueIf.sv
      - fetch/instFetch.sv
      - src/instQueue.sv
      - execute/mipsAlu.sv
      - execute/executeUnit.sv
      - src/mipsCore.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/writebackChecker.sv
      - bench/mipsCoreTb.sv

//--- bench/coreVectors.txt
# P <word>: program word in hex, loaded from word address 0 upward
# E <reg> <data>: expected writeback register and data in hex, in program order
P 2401fff0  # addiu r1, r0, -16
E 01 fffffff0
P 2402ffff  # addiu r2, r0, -1
E 02 ffffffff
P 34038001  # ori r3, r0, 0x8001
E 03 00008001
P 3c048000  # lui r4, 0x8000
E 04 80000000
P 3845f00f  # xori r5, r2, 0xf00f
E 05 ffff0ff0
P 34861234  # ori r6, r4, 0x1234
E 06 80001234
P 00843820  # add r7, r4, r4
E 07 00000000
P 00834022  # sub r8, r4, r3
E 08 7fff7fff
P 00a64824  # and r9, r5, r6
E 09 80000230
P 00645025  # or r10, r3, r4
E 0a 80008001
P 00235827  # nor r11, r1, r3
E 0b 0000000e
P 00a66026  # xor r12, r5, r6
E 0c 7fff1dc4
P 0083682a  # slt r13, r4, r3
E 0d 00000001
P 0083702b  # sltu r14, r4, r3
E 0e 00000000
P 282ffff8  # slti r15, r1, -8
E 0f 00000001
P 2c70ffff  # sltiu r16, r3, -1
E 10 00000001
P 00068900  # sll r17, r6, 4
E 11 00012340
P 00069202  # srl r18, r6, 8
E 12 00800012
P 00069a03  # sra r19, r6, 8
E 13 ff800012
P 0026a004  # sllv r20, r6, r1
E 14 12340000
P 0166a806  # srlv r21, r6, r11
E 15 00020000
P 0044b007  # srav r22, r4, r2
E 16 ffffffff
P 24200005  # addiu r0, r1, 5
P 0003b821  # addu r23, r0, r3
E 17 00008001
P fc000000  # halt

//--- bench/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module mipsCoreTb;
	localparam int maxWords = 1 << `CORE_PROG_ADDR_W;
	localparam int resetCycles = 16;
	localparam int holdCycles = 4; // done must stay up this long

	logic CLK;
	logic reset;
	logic progWrite;
	logic [`CORE_PROG_ADDR_W-1:0] progAddr;
	logic [`CORE_WORD_W-1:0] progData;
	logic start;
	logic wbValid;
	logic [`CORE_REG_ADDR_W-1:0] wbReg;
	logic [`CORE_WORD_W-1:0] wbData;
	logic done;

	logic [`CORE_WORD_W-1:0] progWords [0:maxWords-1];
	int progCount;
	int tbErrors;
	logic vectorsReady;
	int mismatchCount;
	int surplusCount;
	int missingCount;
	int otherCount;

	always #50 CLK = ~CLK;

	mipsCore mipsCore_inst (
		.CLK(CLK),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.start(start),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.done(done)
	);

	writebackChecker wbChecker (
		.CLK(CLK),
		.reset(reset),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.done(done),
		.mismatchCount(mismatchCount),
		.surplusCount(surplusCount),
		.missingCount(missingCount),
		.otherCount(otherCount)
	);

	// P lines go to the program, E lines to the checker
	task automatic readVectors();
		int fd;
		int fields;
		string line;
		logic [31:0] word;
		logic [31:0] regIdx;
		logic [31:0] value;
		fd = $fopen("bench/coreVectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/coreVectors.txt");
			tbErrors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0 && line.len() > 0) begin
					if (line.getc(0) == "P") begin
						fields = $sscanf(line, "P %h", word);
						if (fields != 1 || progCount >= maxWords) begin
							$display("Bad or surplus program line: %s", line);
							tbErrors++;
						end else begin
							progWords[progCount] = word;
							progCount++;
						end
					end else if (line.getc(0) == "E") begin
						fields = $sscanf(line, "E %h %h", regIdx, value);
						if (fields != 2) begin
							$display("Bad expected-result line: %s", line);
							tbErrors++;
						end else begin
							wbChecker.expectWriteback(regIdx[`CORE_REG_ADDR_W-1:0], value);
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runProgram();
		repeat (resetCycles) @(posedge CLK);
		#1;
		reset = 1'b0;
		for (int i = 0; i < progCount; i++) begin // One word per cycle
			@(posedge CLK);
			#1;
			progWrite = 1'b1;
			progAddr = `CORE_PROG_ADDR_W'(i);
			progData = progWords[i];
		end
		@(posedge CLK);
		#1;
		progWrite = 1'b0;
		start = 1'b1;
		@(posedge CLK);
		#1;
		start = 1'b0;
		while (done !== 1'b1)
			@(negedge CLK);
		repeat (holdCycles) @(negedge CLK);
	endtask

	task automatic finishRun();
		int total;
		total = mismatchCount + surplusCount + missingCount + otherCount + tbErrors;
		$display("Errors: %0d mismatch, %0d surplus, %0d missing, %0d done, %0d other",
			mismatchCount, surplusCount, missingCount, otherCount, tbErrors);
		if (total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		start = 1'b0;
		progCount = 0;
		tbErrors = 0;
		vectorsReady = 1'b0;
		readVectors();
		vectorsReady = 1'b1;
		if (progCount > 0) begin
			runProgram();
		end else begin
			$display("No program words were found in the vector file");
			tbErrors++;
		end
		finishRun();
	end

	// Watchdog, sized by program length
	initial begin
		int limit;
		wait (vectorsReady === 1'b1);
		limit = progCount * 6 + 50;
		repeat (limit) @(posedge CLK);
		$display("Timeout: done did not rise within %0d cycles", limit);
		tbErrors++;
		finishRun();
	end

endmodule

`default_nettype wire

//--- bench/writebackChecker.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module writebackChecker (
	input logic CLK,
	input logic reset,
	input logic wbValid,
	input logic [`CORE_REG_ADDR_W-1:0] wbReg,
	input logic [`CORE_WORD_W-1:0] wbData,
	input logic done,
	output int mismatchCount,
	output int surplusCount,
	output int missingCount,
	output int otherCount
);
	localparam int maxExpected = 128;

	logic [`CORE_REG_ADDR_W-1:0] expReg [0:maxExpected-1];
	logic [`CORE_WORD_W-1:0] expData [0:maxExpected-1];
	int expCount = 0;
	int seenCount = 0; // Writebacks observed so far
	logic doneSeen = 1'b0;
	int mismatches = 0;
	int surplus = 0;
	int missing = 0;
	int others = 0;

	assign mismatchCount = mismatches;
	assign surplusCount = surplus;
	assign missingCount = missing;
	assign otherCount = others;

	// Appends one expected writeback, in program order
	function automatic void expectWriteback(input logic [`CORE_REG_ADDR_W-1:0] r,
		input logic [`CORE_WORD_W-1:0] v);
		if (expCount < maxExpected) begin
			expReg[expCount] = r;
			expData[expCount] = v;
			expCount++;
		end else begin
			$display("Too many expected writebacks, limit is %0d", maxExpected);
			others++;
		end
	endfunction

	// Negedge sampling, DUT outputs settle after the rising edge
	always @(negedge CLK) begin
		if (!reset) begin
			if (wbValid === 1'b1) begin
				if (seenCount >= expCount) begin
					$display("Unexpected extra writeback to r%0d with data %h", wbReg, wbData);
					surplus++;
				end else begin
					if (wbReg !== expReg[seenCount]) begin
						$display("MISMATCH wbReg: expected %h, got %h (writeback %0d)",
							expReg[seenCount], wbReg, seenCount);
						mismatches++;
					end
					if (wbData !== expData[seenCount]) begin
						$display("MISMATCH wbData: expected %h, got %h (writeback %0d)",
							expData[seenCount], wbData, seenCount);
						mismatches++;
					end
				end
				seenCount++;
			end
			if (done === 1'b1 && !doneSeen) begin
				doneSeen = 1'b1;
				if (seenCount < expCount) begin // Program ended early
					$display("done rose with %0d expected writebacks never seen",
						expCount - seenCount);
					missing += expCount - seenCount;
				end
			end else if (done !== 1'b1 && doneSeen) begin
				$display("done dropped again without a new start");
				others++;
				doneSeen = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- common/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath and instruction width
`define CORE_WORD_W 32

// Register index, 32 entries
`define CORE_REG_ADDR_W 5

// Instruction memory, bytes and byte address width
`define CORE_MEM_BYTES 512
`define CORE_PC_W 9

// Word index on the program load port
`define CORE_PROG_ADDR_W 7

`define CORE_QUEUE_DEPTH 4

`endif

//--- common/mipsCorePkg.sv
`default_nettype none

package mipsCorePkg;

	// ALU operations, shared by decode and the ALU
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNor,
		aluXor,
		aluSlt, // Signed compare
		aluSltu, // Unsigned compare
		aluSll,
		aluSrl,
		aluSra,
		aluLui
	} aluOpE;

	// Fetch sequence, one word per address/read/push round
	typedef enum logic [1:0] {
		fetchIdle,
		fetchAddr,
		fetchRead,
		fetchPush
	} fetchStateE;

	typedef enum logic [1:0] {
		execIdle, // Pop when the queue has a word
		execDecode,
		execExecute,
		execFinished // Holds done until the next start
	} execStateE;

endpackage

`default_nettype wire

//--- common/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	// Instruction field positions
	localparam int opcodeLsb = 26;
	localparam int opcodeW = 6;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;
	localparam int saLsb = 6;
	localparam int functW = 6;
	localparam int immW = 16;

	typedef enum logic [5:0] {
		opSpecial = 6'b000000, // R-type, funct decides
		opAddi = 6'b001000,
		opAddiu = 6'b001001,
		opSlti = 6'b001010,
		opSltiu = 6'b001011,
		opAndi = 6'b001100,
		opOri = 6'b001101,
		opXori = 6'b001110,
		opLui = 6'b001111,
		opHalt = 6'b111111 // End of program, never issued
	} opcodeE;

	typedef enum logic [5:0] {
		fnSll = 6'b000000,
		fnSrl = 6'b000010,
		fnSra = 6'b000011,
		fnSllv = 6'b000100,
		fnSrlv = 6'b000110,
		fnSrav = 6'b000111,
		fnAdd = 6'b100000,
		fnAddu = 6'b100001,
		fnSub = 6'b100010,
		fnSubu = 6'b100011,
		fnAnd = 6'b100100,
		fnOr = 6'b100101,
		fnXor = 6'b100110,
		fnNor = 6'b100111,
		fnSlt = 6'b101010,
		fnSltu = 6'b101011
	} functE;

endpackage

`default_nettype wire

//--- common/queueIf.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

// Fetch side of the instruction queue
interface fetchPushIf;
	logic push;
	logic [`CORE_WORD_W-1:0] word;
	logic last; // Final word of the program
	logic full;

	modport writer (output push, output word, output last, input full);
	modport queueSide (input push, input word, input last, output full);
endinterface

// Execute side, head entry is always visible
interface issuePopIf;
	logic pop;
	logic [`CORE_WORD_W-1:0] word;
	logic last;
	logic empty;

	modport reader (output pop, input word, input last, input empty);
	modport queueSide (input pop, output word, output last, output empty);
endinterface

`default_nettype wire

//--- execute/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module executeUnit (
	input logic CLK,
	input logic reset,
	input logic start,
	issuePopIf.reader popPort,
	output logic wbValid,
	output logic [`CORE_REG_ADDR_W-1:0] wbReg,
	output logic [`CORE_WORD_W-1:0] wbData,
	output logic done
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	localparam int regCount = 1 << `CORE_REG_ADDR_W;

	execStateE state;
	logic [`CORE_WORD_W-1:0] regFile [0:regCount-1];
	logic [`CORE_WORD_W-1:0] instReg;
	logic lastReg;

	opcodeE opcode;
	functE funct;
	logic [`CORE_REG_ADDR_W-1:0] rs, rt, rd, sa;
	logic [immW-1:0] imm;
	logic [`CORE_WORD_W-1:0] rsVal, rtVal, immExt, saExt;
	logic useImm, zeroExt, shiftOp, shiftVar, legal;
	logic [`CORE_REG_ADDR_W-1:0] decDest;
	aluOpE decOp;

	aluOpE aluOp;
	logic [`CORE_WORD_W-1:0] opA, opB, aluResult;
	logic [`CORE_REG_ADDR_W-1:0] destReg;
	logic writeReg;

	// Field split
	assign opcode = opcodeE'(instReg[opcodeLsb +: opcodeW]);
	assign funct = functE'(instReg[functW-1:0]);
	assign rs = instReg[rsLsb +: `CORE_REG_ADDR_W];
	assign rt = instReg[rtLsb +: `CORE_REG_ADDR_W];
	assign rd = instReg[rdLsb +: `CORE_REG_ADDR_W];
	assign sa = instReg[saLsb +: `CORE_REG_ADDR_W];
	assign imm = instReg[immW-1:0];

	assign useImm = (opcode != opSpecial);
	assign zeroExt = opcode inside {opAndi, opOri, opXori}; // Logic immediates only
	assign shiftOp = !useImm && (decOp inside {aluSll, aluSrl, aluSra});
	assign shiftVar = funct inside {fnSllv, fnSrlv, fnSrav};
	assign decDest = useImm ? rt : rd;

	assign rsVal = regFile[rs];
	assign rtVal = regFile[rt];
	assign saExt = {{(`CORE_WORD_W - `CORE_REG_ADDR_W){1'b0}}, sa};
	assign immExt = zeroExt ? {{(`CORE_WORD_W - immW){1'b0}}, imm}
		: {{(`CORE_WORD_W - immW){imm[immW-1]}}, imm};

	always_comb begin
		decOp = aluAdd;
		legal = 1'b1;
		case (opcode)
			opSpecial: begin
				case (funct)
					fnAdd, fnAddu: decOp = aluAdd; // No overflow trap
					fnSub, fnSubu: decOp = aluSub;
					fnAnd: decOp = aluAnd;
					fnOr: decOp = aluOr;
					fnNor: decOp = aluNor;
					fnXor: decOp = aluXor;
					fnSlt: decOp = aluSlt;
					fnSltu: decOp = aluSltu;
					fnSll, fnSllv: decOp = aluSll;
					fnSrl, fnSrlv: decOp = aluSrl;
					fnSra, fnSrav: decOp = aluSra;
					default: legal = 1'b0;
				endcase
			end
			opAddi, opAddiu: decOp = aluAdd;
			opSlti: decOp = aluSlt;
			opSltiu: decOp = aluSltu; // Sign-extended, compared unsigned
			opAndi: decOp = aluAnd;
			opOri: decOp = aluOr;
			opXori: decOp = aluXor;
			opLui: decOp = aluLui;
			default: legal = 1'b0;
		endcase
	end

	assign popPort.pop = (state == execIdle) && !popPort.empty;
	assign done = (state == execFinished);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= execIdle;
			wbValid <= 1'b0;
		end else begin
			wbValid <= 1'b0;
			case (state)
				execIdle: if (!popPort.empty) state <= execDecode;
				execDecode: state <= execExecute;
				execExecute: begin
					wbValid <= writeReg;
					state <= lastReg ? execFinished : execIdle;
				end
				execFinished: if (start) state <= execIdle;
				default: state <= execIdle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (popPort.pop) begin
			instReg <= popPort.word;
			lastReg <= popPort.last;
		end
		if (state == execDecode) begin
			aluOp <= decOp;
			opA <= shiftOp ? rtVal : rsVal; // Shifts act on rt
			opB <= shiftOp ? (shiftVar ? rsVal : saExt) : (useImm ? immExt : rtVal);
			destReg <= decDest;
			writeReg <= legal && (decDest != '0); // r0 stays zero
		end
		if (state == execExecute) begin
			wbReg <= destReg;
			wbData <= aluResult;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++)
				regFile[i] <= '0;
		end else if (state == execExecute && writeReg) begin
			regFile[destReg] <= aluResult;
		end
	end

	mipsAlu mipsAlu_inst (
		.op(aluOp),
		.a(opA),
		.b(opB),
		.result(aluResult)
	);

endmodule

`default_nettype wire

//--- execute/mipsAlu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module mipsAlu (
	input mipsCorePkg::aluOpE op,
	input logic [`CORE_WORD_W-1:0] a,
	input logic [`CORE_WORD_W-1:0] b,
	output logic [`CORE_WORD_W-1:0] result
);
	import mipsCorePkg::*;

	localparam int halfW = `CORE_WORD_W / 2;

	logic [4:0] shamt;
	logic signedLess;
	logic unsignedLess;

	assign shamt = b[4:0]; // Upper bits of the amount are ignored
	assign signedLess = ($signed(a) < $signed(b));
	assign unsignedLess = (a < b);

	always_comb begin
		case (op)
			aluAdd: result = a + b; // Wraps, no trap
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluNor: result = ~(a | b);
			aluXor: result = a ^ b;
			aluSlt: result = {{(`CORE_WORD_W - 1){1'b0}}, signedLess};
			aluSltu: result = {{(`CORE_WORD_W - 1){1'b0}}, unsignedLess};
			aluSll: result = a << shamt;
			aluSrl: result = a >> shamt;
			aluSra: result = $unsigned($signed(a) >>> shamt); // Sign fill
			aluLui: result = {b[halfW-1:0], {halfW{1'b0}}};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- fetch/instFetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module instFetch (
	input logic CLK,
	input logic reset,
	input logic progWrite,
	input logic [`CORE_PROG_ADDR_W-1:0] progAddr,
	input logic [`CORE_WORD_W-1:0] progData,
	input logic start,
	fetchPushIf.writer pushPort
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	logic [7:0] mem [0:`CORE_MEM_BYTES-1];
	logic [`CORE_PC_W-1:0] pc;
	logic [`CORE_PC_W-1:0] memAddr;
	logic [`CORE_WORD_W-1:0] readWord;
	logic [`CORE_WORD_W-1:0] heldWord; // One word kept back for the last mark
	logic heldValid;
	logic isHalt;
	logic advance;
	fetchStateE state;

	assign isHalt = (readWord[opcodeLsb +: opcodeW] == opHalt);

	// Held word may move on once the queue takes it, or at once if nothing is held
	assign advance = !heldValid || !pushPort.full;

	// Halt first pushes an all-zero word, which is SLL r0
	assign pushPort.push = (state == fetchPush) && !pushPort.full && (heldValid || isHalt);
	assign pushPort.word = heldValid ? heldWord : '0;
	assign pushPort.last = isHalt;

	// Big-endian load, MSB at the lowest byte
	always_ff @(posedge CLK) begin
		if (progWrite) begin
			mem[{progAddr, 2'b00}] <= progData[31:24];
			mem[{progAddr, 2'b01}] <= progData[23:16];
			mem[{progAddr, 2'b10}] <= progData[15:8];
			mem[{progAddr, 2'b11}] <= progData[7:0];
		end
	end

	always_ff @(posedge CLK) begin
		if (state == fetchAddr)
			memAddr <= pc;
		if (state == fetchRead) begin
			readWord <= {mem[{memAddr[`CORE_PC_W-1:2], 2'b00}],
				mem[{memAddr[`CORE_PC_W-1:2], 2'b01}],
				mem[{memAddr[`CORE_PC_W-1:2], 2'b10}],
				mem[{memAddr[`CORE_PC_W-1:2], 2'b11}]};
		end
		if (state == fetchPush && !isHalt && advance)
			heldWord <= readWord;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= fetchIdle;
			pc <= '0;
			heldValid <= 1'b0;
		end else begin
			case (state)
				fetchIdle: begin
					if (start) begin
						pc <= '0;
						heldValid <= 1'b0;
						state <= fetchAddr;
					end
				end
				fetchAddr: state <= fetchRead;
				fetchRead: state <= fetchPush;
				fetchPush: begin
					if (isHalt) begin
						if (!pushPort.full) begin // Last word gone, stop here
							heldValid <= 1'b0;
							state <= fetchIdle;
						end
					end else if (advance) begin
						heldValid <= 1'b1;
						pc <= pc + `CORE_PC_W'(4);
						state <= fetchAddr;
					end
				end
				default: state <= fetchIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/mipsIsaPkg.sv
common/mipsCorePkg.sv
common/queueIf.sv
fetch/instFetch.sv
src/instQueue.sv
execute/mipsAlu.sv
execute/executeUnit.sv
src/mipsCore.sv
bench/writebackChecker.sv
bench/mipsCoreTb.sv

//--- src/instQueue.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module instQueue #(
	parameter int depth = `CORE_QUEUE_DEPTH
) (
	input logic CLK,
	input logic reset,
	fetchPushIf.queueSide pushPort,
	issuePopIf.queueSide popPort
);
	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	logic [`CORE_WORD_W-1:0] wordMem [0:depth-1];
	logic lastMem [0:depth-1];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic doPush;
	logic doPop;

	// Wraps at depth, also for depths that are not a power of two
	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
		if (ptr == ptrW'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign doPush = pushPort.push && !pushPort.full;
	assign doPop = popPort.pop && !popPort.empty;

	assign pushPort.full = (count == cntW'(depth));
	assign popPort.empty = (count == '0);
	assign popPort.word = wordMem[rdPtr];
	assign popPort.last = lastMem[rdPtr];

	always_ff @(posedge CLK) begin
		if (doPush) begin
			wordMem[wrPtr] <= pushPort.word;
			lastMem[wrPtr] <= pushPort.last;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module mipsCore (
	input logic CLK,
	input logic reset,
	input logic progWrite,
	input logic [`CORE_PROG_ADDR_W-1:0] progAddr,
	input logic [`CORE_WORD_W-1:0] progData,
	input logic start,
	output logic wbValid,
	output logic [`CORE_REG_ADDR_W-1:0] wbReg,
	output logic [`CORE_WORD_W-1:0] wbData,
	output logic done
);

	fetchPushIf pushBus ();
	issuePopIf popBus ();

	// Producer, loads the program and streams words
	instFetch instFetch_inst (
		.CLK(CLK),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.start(start),
		.pushPort(pushBus.writer)
	);

	instQueue #(
		.depth(`CORE_QUEUE_DEPTH)
	) instQueue_inst (
		.CLK(CLK),
		.reset(reset),
		.pushPort(pushBus.queueSide),
		.popPort(popBus.queueSide)
	);

	// Consumer, decode through writeback
	executeUnit executeUnit_inst (
		.CLK(CLK),
		.reset(reset),
		.start(start),
		.popPort(popBus.reader),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.done(done)
	);

endmodule

`default_nettype wire
